//--- hw/ctrl_pkg.sv
package ctrl_pkg;

    // reorder buffer geometry
    localparam int ROB_SIZE  = 8;
    localparam int ROB_IDX_W = 3;

    // datapath and register file widths
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // functional unit classes
    localparam int FU_W = 2;

    localparam logic [FU_W-1:0] FU_ALU     = 2'd0;
    localparam logic [FU_W-1:0] FU_LSU     = 2'd1;
    localparam logic [FU_W-1:0] FU_BRU     = 2'd2;
    // unknown opcode, still dispatched so the ROB can raise it at commit
    localparam logic [FU_W-1:0] FU_ILLEGAL = 2'd3;

    // major opcodes understood by the decoder
    localparam logic [6:0] OP_REG  = 7'b0110011;
    localparam logic [6:0] OP_IMM  = 7'b0010011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_JALR = 7'b1100111;

    // one fetched word, viewed either as register-register or register-immediate
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [REG_IDX_W-1:0] rs2;
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } r_fmt;
        struct packed {
            logic [11:0]          imm12;
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } i_fmt;
    } inst_word_t;

endpackage

//--- hw/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  ctrl_pkg::inst_word_t             i_inst,

    output logic [ctrl_pkg::FU_W-1:0]        o_fu,
    output logic [ctrl_pkg::REG_IDX_W-1:0]   o_rd,
    output logic [ctrl_pkg::REG_IDX_W-1:0]   o_rs1,
    output logic [ctrl_pkg::REG_IDX_W-1:0]   o_rs2,
    output logic                             o_rd_wen,
    output logic [ctrl_pkg::XLEN-1:0]        o_imm,
    output logic                             o_illegal
);

    logic [ctrl_pkg::XLEN-1:0] imm_sext;

    // imm12 sign extended, shared by every I-format opcode
    assign imm_sext = {{(ctrl_pkg::XLEN-12){i_inst.i_fmt.imm12[11]}}, i_inst.i_fmt.imm12};

    always_comb begin
        // unknown opcode by default
        o_fu      = ctrl_pkg::FU_ILLEGAL;
        o_rd      = '0;
        o_rs1     = '0;
        o_rs2     = '0;
        o_rd_wen  = 1'b0;
        o_imm     = '0;
        o_illegal = 1'b1;

        case (i_inst.r_fmt.opcode)
            ctrl_pkg::OP_REG: begin
                o_fu      = ctrl_pkg::FU_ALU;
                o_rd      = i_inst.r_fmt.rd;
                o_rs1     = i_inst.r_fmt.rs1;
                o_rs2     = i_inst.r_fmt.rs2;
                o_rd_wen  = 1'b1;
                o_illegal = 1'b0;
            end
            ctrl_pkg::OP_IMM,
            ctrl_pkg::OP_LOAD,
            ctrl_pkg::OP_JALR: begin
                o_rd      = i_inst.i_fmt.rd;
                o_rs1     = i_inst.i_fmt.rs1;
                o_rd_wen  = 1'b1;
                o_imm     = imm_sext;
                o_illegal = 1'b0;
                // unit class from the opcode, format is the same
                if (i_inst.i_fmt.opcode == ctrl_pkg::OP_LOAD) begin
                    o_fu = ctrl_pkg::FU_LSU;
                end else if (i_inst.i_fmt.opcode == ctrl_pkg::OP_JALR) begin
                    o_fu = ctrl_pkg::FU_BRU;
                end else begin
                    o_fu = ctrl_pkg::FU_ALU;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hw/rob.sv
`timescale 1ns/1ps

module rob (
    input  logic                              clk,
    input  logic                              i_rst_n,

    // allocation from dispatch
    input  logic                              i_alloc_valid,
    input  logic                              i_alloc_except,
    output logic                              o_can_alloc,
    output logic [ctrl_pkg::ROB_IDX_W-1:0]    o_alloc_idx,

    // writeback from execution
    input  logic                              i_wb_valid,
    input  logic [ctrl_pkg::ROB_IDX_W-1:0]    i_wb_rob_idx,

    // in-order retire
    output logic                              o_commit_valid,
    output logic [ctrl_pkg::ROB_IDX_W-1:0]    o_commit_rob_idx,
    output logic                              o_commit_except
);

    logic [ctrl_pkg::ROB_SIZE-1:0] valid_q;
    logic [ctrl_pkg::ROB_SIZE-1:0] done_q;
    logic [ctrl_pkg::ROB_SIZE-1:0] except_q;

    // top bit is the wrap flag
    logic [ctrl_pkg::ROB_IDX_W:0]   head_q;
    logic [ctrl_pkg::ROB_IDX_W:0]   tail_q;

    logic [ctrl_pkg::ROB_IDX_W-1:0] head_idx;
    logic [ctrl_pkg::ROB_IDX_W-1:0] tail_idx;
    logic                           full;
    logic                           alloc_fire;
    logic                           wb_fire;
    logic                           commit_fire;

    assign head_idx = head_q[ctrl_pkg::ROB_IDX_W-1:0];
    assign tail_idx = tail_q[ctrl_pkg::ROB_IDX_W-1:0];

    // same slot, opposite lap
    assign full = (head_idx == tail_idx)
               && (head_q[ctrl_pkg::ROB_IDX_W] != tail_q[ctrl_pkg::ROB_IDX_W]);

    assign alloc_fire  = i_alloc_valid && !full;
    // stray writeback to a free slot is dropped
    assign wb_fire     = i_wb_valid && valid_q[i_wb_rob_idx];
    assign commit_fire = valid_q[head_idx] && done_q[head_idx];

    assign o_can_alloc      = !full;
    assign o_alloc_idx      = tail_idx;
    assign o_commit_valid   = commit_fire;
    assign o_commit_rob_idx = head_idx;
    assign o_commit_except  = except_q[head_idx];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (alloc_fire) begin
                valid_q[tail_idx] <= 1'b1;
                // faulting entries need no writeback
                done_q[tail_idx]  <= i_alloc_except;
                tail_q            <= tail_q + 1'b1;
            end
            if (wb_fire) begin
                done_q[i_wb_rob_idx] <= 1'b1;
            end
            // head retire last, frees the slot
            if (commit_fire) begin
                valid_q[head_idx] <= 1'b0;
                done_q[head_idx]  <= 1'b0;
                head_q            <= head_q + 1'b1;
            end
        end
    end

    // fault flag captured at allocation
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            except_q[tail_idx] <= i_alloc_except;
        end
    end

endmodule

//--- hw/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage (
    input  logic                              clk,
    input  logic                              i_rst_n,

    // fetch handshake
    input  logic                              i_inst_valid,
    output logic                              o_inst_ready,

    // decode results
    input  logic [ctrl_pkg::FU_W-1:0]         i_fu,
    input  logic [ctrl_pkg::REG_IDX_W-1:0]    i_rd,
    input  logic                              i_rd_wen,
    input  logic [ctrl_pkg::REG_IDX_W-1:0]    i_rs1,
    input  logic [ctrl_pkg::REG_IDX_W-1:0]    i_rs2,
    input  logic [ctrl_pkg::XLEN-1:0]         i_imm,
    input  logic                              i_illegal,

    // rob allocation
    input  logic                              i_can_alloc,
    input  logic [ctrl_pkg::ROB_IDX_W-1:0]    i_alloc_idx,
    output logic                              o_alloc_valid,
    output logic                              o_alloc_except,

    // dispatch handshake
    input  logic                              i_disp_ready,
    output logic                              o_disp_valid,
    output logic [ctrl_pkg::FU_W-1:0]         o_disp_fu,
    output logic [ctrl_pkg::REG_IDX_W-1:0]    o_disp_rd,
    output logic                              o_disp_rd_wen,
    output logic [ctrl_pkg::REG_IDX_W-1:0]    o_disp_rs1,
    output logic [ctrl_pkg::REG_IDX_W-1:0]    o_disp_rs2,
    output logic [ctrl_pkg::XLEN-1:0]         o_disp_imm,
    output logic [ctrl_pkg::ROB_IDX_W-1:0]    o_disp_rob_idx
);

    logic inst_fire;

    // accept when a rob slot is free and the packet register frees this cycle
    assign o_inst_ready   = i_can_alloc && (!o_disp_valid || i_disp_ready);
    assign inst_fire      = i_inst_valid && o_inst_ready;

    assign o_alloc_valid  = inst_fire;
    assign o_alloc_except = i_illegal;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_disp_valid <= 1'b0;
        end else if (inst_fire) begin
            o_disp_valid <= 1'b1;
        end else if (i_disp_ready) begin
            o_disp_valid <= 1'b0;
        end
    end

    // packet payload, replaced on the edge the old one leaves
    always_ff @(posedge clk) begin
        if (inst_fire) begin
            o_disp_fu      <= i_fu;
            o_disp_rd      <= i_rd;
            o_disp_rd_wen  <= i_rd_wen;
            o_disp_rs1     <= i_rs1;
            o_disp_rs2     <= i_rs2;
            o_disp_imm     <= i_imm;
            o_disp_rob_idx <= i_alloc_idx;
        end
    end

endmodule

//--- hw/ctrl_block.sv
`timescale 1ns/1ps

// decode -> dispatch -> rob
module ctrl_block (
    input  logic                              clk,
    input  logic                              i_rst_n,

    // from fetch
    input  logic                              i_inst_valid,
    input  ctrl_pkg::inst_word_t              i_inst,
    output logic                              o_inst_ready,

    // to execution
    output logic                              o_disp_valid,
    output logic [ctrl_pkg::FU_W-1:0]         o_disp_fu,
    output logic [ctrl_pkg::REG_IDX_W-1:0]    o_disp_rd,
    output logic                              o_disp_rd_wen,
    output logic [ctrl_pkg::REG_IDX_W-1:0]    o_disp_rs1,
    output logic [ctrl_pkg::REG_IDX_W-1:0]    o_disp_rs2,
    output logic [ctrl_pkg::XLEN-1:0]         o_disp_imm,
    output logic [ctrl_pkg::ROB_IDX_W-1:0]    o_disp_rob_idx,
    input  logic                              i_disp_ready,

    // writeback by rob index
    input  logic                              i_wb_valid,
    input  logic [ctrl_pkg::ROB_IDX_W-1:0]    i_wb_rob_idx,

    // retire
    output logic                              o_commit_valid,
    output logic [ctrl_pkg::ROB_IDX_W-1:0]    o_commit_rob_idx,
    output logic                              o_commit_except
);

    logic [ctrl_pkg::FU_W-1:0]      dec_fu;
    logic [ctrl_pkg::REG_IDX_W-1:0] dec_rd;
    logic [ctrl_pkg::REG_IDX_W-1:0] dec_rs1;
    logic [ctrl_pkg::REG_IDX_W-1:0] dec_rs2;
    logic                           dec_rd_wen;
    logic [ctrl_pkg::XLEN-1:0]      dec_imm;
    logic                           dec_illegal;

    logic                           rob_can_alloc;
    logic [ctrl_pkg::ROB_IDX_W-1:0] rob_alloc_idx;
    logic                           rob_alloc_valid;
    logic                           rob_alloc_except;

    inst_decode u_inst_decode (
        .i_inst    ( i_inst      ),
        .o_fu      ( dec_fu      ),
        .o_rd      ( dec_rd      ),
        .o_rs1     ( dec_rs1     ),
        .o_rs2     ( dec_rs2     ),
        .o_rd_wen  ( dec_rd_wen  ),
        .o_imm     ( dec_imm     ),
        .o_illegal ( dec_illegal )
    );

    // free slot offered in parallel with decode
    rob u_rob (
        .clk              ( clk              ),
        .i_rst_n          ( i_rst_n          ),
        .i_alloc_valid    ( rob_alloc_valid  ),
        .i_alloc_except   ( rob_alloc_except ),
        .o_can_alloc      ( rob_can_alloc    ),
        .o_alloc_idx      ( rob_alloc_idx    ),
        .i_wb_valid       ( i_wb_valid       ),
        .i_wb_rob_idx     ( i_wb_rob_idx     ),
        .o_commit_valid   ( o_commit_valid   ),
        .o_commit_rob_idx ( o_commit_rob_idx ),
        .o_commit_except  ( o_commit_except  )
    );

    dispatch_stage u_dispatch_stage (
        .clk            ( clk              ),
        .i_rst_n        ( i_rst_n          ),
        .i_inst_valid   ( i_inst_valid     ),
        .o_inst_ready   ( o_inst_ready     ),
        .i_fu           ( dec_fu           ),
        .i_rd           ( dec_rd           ),
        .i_rd_wen       ( dec_rd_wen       ),
        .i_rs1          ( dec_rs1          ),
        .i_rs2          ( dec_rs2          ),
        .i_imm          ( dec_imm          ),
        .i_illegal      ( dec_illegal      ),
        .i_can_alloc    ( rob_can_alloc    ),
        .i_alloc_idx    ( rob_alloc_idx    ),
        .o_alloc_valid  ( rob_alloc_valid  ),
        .o_alloc_except ( rob_alloc_except ),
        .i_disp_ready   ( i_disp_ready     ),
        .o_disp_valid   ( o_disp_valid     ),
        .o_disp_fu      ( o_disp_fu        ),
        .o_disp_rd      ( o_disp_rd        ),
        .o_disp_rd_wen  ( o_disp_rd_wen    ),
        .o_disp_rs1     ( o_disp_rs1       ),
        .o_disp_rs2     ( o_disp_rs2       ),
        .o_disp_imm     ( o_disp_imm       ),
        .o_disp_rob_idx ( o_disp_rob_idx   )
    );

endmodule

//--- tb/ctrl_block_chk.sv
`timescale 1ns/1ps

module ctrl_block_chk (
    input logic                              clk,
    input logic                              i_rst_n,
    input logic                              i_inst_valid,
    input logic                              o_inst_ready,
    input logic                              o_disp_valid,
    input logic                              i_disp_ready,
    input logic [ctrl_pkg::FU_W-1:0]         o_disp_fu,
    input logic [ctrl_pkg::REG_IDX_W-1:0]    o_disp_rd,
    input logic                              o_disp_rd_wen,
    input logic [ctrl_pkg::REG_IDX_W-1:0]    o_disp_rs1,
    input logic [ctrl_pkg::REG_IDX_W-1:0]    o_disp_rs2,
    input logic [ctrl_pkg::XLEN-1:0]         o_disp_imm,
    input logic [ctrl_pkg::ROB_IDX_W-1:0]    o_disp_rob_idx,
    input logic                              o_commit_valid
);

    int assert_fails = 0;

    logic [ctrl_pkg::ROB_IDX_W:0] outstanding;
    logic [52:0]                  packet;

    assign packet = {o_disp_fu, o_disp_rd, o_disp_rd_wen, o_disp_rs1, o_disp_rs2,
                     o_disp_imm, o_disp_rob_idx};

    // entries allocated and not yet retired
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            outstanding <= '0;
        end else if ((i_inst_valid && o_inst_ready) && !o_commit_valid) begin
            outstanding <= outstanding + 1'b1;
        end else if (!(i_inst_valid && o_inst_ready) && o_commit_valid) begin
            outstanding <= outstanding - 1'b1;
        end
    end

    a_disp_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_disp_valid && !i_disp_ready |=> o_disp_valid && $stable(packet))
        else begin
            assert_fails++;
            $error("dispatch packet changed while stalled");
        end

    a_commit_alloc: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_commit_valid |-> (outstanding != '0))
        else begin
            assert_fails++;
            $error("commit with no allocated entry");
        end

    a_full_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
        (outstanding == ctrl_pkg::ROB_SIZE) |-> !o_inst_ready)
        else begin
            assert_fails++;
            $error("fetch ready while the rob is full");
        end

endmodule

bind ctrl_block ctrl_block_chk u_ctrl_block_chk (
    .clk            ( clk            ),
    .i_rst_n        ( i_rst_n        ),
    .i_inst_valid   ( i_inst_valid   ),
    .o_inst_ready   ( o_inst_ready   ),
    .o_disp_valid   ( o_disp_valid   ),
    .i_disp_ready   ( i_disp_ready   ),
    .o_disp_fu      ( o_disp_fu      ),
    .o_disp_rd      ( o_disp_rd      ),
    .o_disp_rd_wen  ( o_disp_rd_wen  ),
    .o_disp_rs1     ( o_disp_rs1     ),
    .o_disp_rs2     ( o_disp_rs2     ),
    .o_disp_imm     ( o_disp_imm     ),
    .o_disp_rob_idx ( o_disp_rob_idx ),
    .o_commit_valid ( o_commit_valid )
);

//--- tb/ctrl_block_tb.sv
`timescale 1ns/1ps

module ctrl_block_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int SEND_LIMIT      = 20;

    logic                           clk;
    logic                           i_rst_n;
    logic                           i_inst_valid;
    ctrl_pkg::inst_word_t           i_inst;
    logic                           o_inst_ready;
    logic                           o_disp_valid;
    logic [ctrl_pkg::FU_W-1:0]      o_disp_fu;
    logic [ctrl_pkg::REG_IDX_W-1:0] o_disp_rd;
    logic                           o_disp_rd_wen;
    logic [ctrl_pkg::REG_IDX_W-1:0] o_disp_rs1;
    logic [ctrl_pkg::REG_IDX_W-1:0] o_disp_rs2;
    logic [ctrl_pkg::XLEN-1:0]      o_disp_imm;
    logic [ctrl_pkg::ROB_IDX_W-1:0] o_disp_rob_idx;
    logic                           i_disp_ready;
    logic                           i_wb_valid;
    logic [ctrl_pkg::ROB_IDX_W-1:0] i_wb_rob_idx;
    logic                           o_commit_valid;
    logic [ctrl_pkg::ROB_IDX_W-1:0] o_commit_rob_idx;
    logic                           o_commit_except;

    logic [31:0]                    rng_state;
    int                             err_count;
    int                             tests_run;
    int                             tests_failed;
    // rob index the next allocation should get
    logic [ctrl_pkg::ROB_IDX_W-1:0] next_idx;

    ctrl_block ctrl_block_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("watchdog expired, the run did not finish in %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] lcg_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        // fold high bits down, low LCG bits cycle fast
        return rng_state ^ (rng_state >> 16);
    endfunction

    function automatic ctrl_pkg::inst_word_t make_r(
        input logic [ctrl_pkg::REG_IDX_W-1:0] rd,
        input logic [ctrl_pkg::REG_IDX_W-1:0] rs1,
        input logic [ctrl_pkg::REG_IDX_W-1:0] rs2
    );
        ctrl_pkg::inst_word_t w;
        w.r_fmt.funct7 = 7'b0100000;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = 3'b101;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = ctrl_pkg::OP_REG;
        return w;
    endfunction

    function automatic ctrl_pkg::inst_word_t make_i(
        input logic [6:0]                     op,
        input logic [ctrl_pkg::REG_IDX_W-1:0] rd,
        input logic [ctrl_pkg::REG_IDX_W-1:0] rs1,
        input logic [11:0]                    imm12
    );
        ctrl_pkg::inst_word_t w;
        w.i_fmt.imm12  = imm12;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.funct3 = 3'b010;
        w.i_fmt.rd     = rd;
        w.i_fmt.opcode = op;
        return w;
    endfunction

    task automatic check_disp(
        input string                          name,
        input logic [ctrl_pkg::FU_W-1:0]      exp_fu,
        input logic [ctrl_pkg::REG_IDX_W-1:0] exp_rd,
        input logic                           exp_wen,
        input logic [ctrl_pkg::REG_IDX_W-1:0] exp_rs1,
        input logic [ctrl_pkg::REG_IDX_W-1:0] exp_rs2,
        input logic [ctrl_pkg::XLEN-1:0]      exp_imm,
        input logic [ctrl_pkg::ROB_IDX_W-1:0] exp_idx
    );
        if (o_disp_valid !== 1'b1) begin
            $display("%s: no dispatch packet where one was due", name);
            err_count++;
        end else if ({o_disp_fu, o_disp_rd, o_disp_rd_wen, o_disp_rs1, o_disp_rs2,
                      o_disp_imm, o_disp_rob_idx} !==
                     {exp_fu, exp_rd, exp_wen, exp_rs1, exp_rs2, exp_imm, exp_idx}) begin
            $display("ERR %s: expected fu=%0d rd=%0d wen=%b rs1=%0d rs2=%0d imm=%h rob=%0d",
                     name, exp_fu, exp_rd, exp_wen, exp_rs1, exp_rs2, exp_imm, exp_idx);
            $display("ERR %s: actual   fu=%0d rd=%0d wen=%b rs1=%0d rs2=%0d imm=%h rob=%0d",
                     name, o_disp_fu, o_disp_rd, o_disp_rd_wen, o_disp_rs1, o_disp_rs2,
                     o_disp_imm, o_disp_rob_idx);
            err_count++;
        end
    endtask

    task automatic check_commit(
        input string                          name,
        input logic                           exp_valid,
        input logic [ctrl_pkg::ROB_IDX_W-1:0] exp_idx,
        input logic                           exp_except
    );
        if (o_commit_valid !== exp_valid) begin
            $display("ERR %s: expected commit_valid=%b, actual %b", name, exp_valid,
                     o_commit_valid);
            err_count++;
        end else if (exp_valid &&
                     {o_commit_rob_idx, o_commit_except} !== {exp_idx, exp_except}) begin
            $display("ERR %s: expected commit rob=%0d except=%b, actual rob=%0d except=%b",
                     name, exp_idx, exp_except, o_commit_rob_idx, o_commit_except);
            err_count++;
        end
    endtask

    task automatic check_ready(input string name, input logic exp_ready);
        if (o_inst_ready !== exp_ready) begin
            $display("ERR %s: expected inst_ready=%b, actual %b", name, exp_ready,
                     o_inst_ready);
            err_count++;
        end
    endtask

    // starts at a falling edge, returns just after the transfer edge
    task automatic send_inst(input string name, input ctrl_pkg::inst_word_t word);
        logic sent;
        int   waited;
        sent   = 1'b0;
        waited = 0;
        i_inst_valid = 1'b1;
        i_inst       = word;
        while (!sent && waited < SEND_LIMIT) begin
            #(CLK_PERIOD/4);
            sent = (o_inst_ready === 1'b1);
            @(posedge clk);
            if (!sent) begin
                waited++;
                @(negedge clk);
            end
        end
        if (!sent) begin
            $display("%s: fetch transfer not accepted within %0d cycles", name, SEND_LIMIT);
            err_count++;
        end
        next_idx++;
    endtask

    // writeback one entry that is the head, expect it to commit once
    task automatic retire_one(input string name, input logic [ctrl_pkg::ROB_IDX_W-1:0] idx);
        i_wb_valid   = 1'b1;
        i_wb_rob_idx = idx;
        @(negedge clk);
        i_wb_valid = 1'b0;
        check_commit(name, 1'b1, idx, 1'b0);
        @(negedge clk);
        check_commit(name, 1'b0, '0, 1'b0);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic test_reg_decode();
        int                             errs;
        logic [31:0]                    r;
        logic [ctrl_pkg::ROB_IDX_W-1:0] idx;
        errs = err_count;
        for (int k = 0; k < 4; k++) begin
            r   = lcg_rand();
            idx = next_idx;
            send_inst("reg_decode", make_r(r[4:0], r[9:5], r[14:10]));
            @(negedge clk);
            i_inst_valid = 1'b0;
            check_disp("reg_decode", ctrl_pkg::FU_ALU, r[4:0], 1'b1, r[9:5], r[14:10], '0, idx);
            check_commit("reg_decode", 1'b0, '0, 1'b0);
            retire_one("reg_decode", idx);
        end
        report_test("reg_decode", errs);
    endtask

    task automatic test_imm_decode();
        int                             errs;
        logic [31:0]                    r;
        logic [11:0]                    imm12;
        logic [6:0]                     op;
        logic [ctrl_pkg::FU_W-1:0]      fu;
        logic [ctrl_pkg::XLEN-1:0]      exp_imm;
        logic [ctrl_pkg::ROB_IDX_W-1:0] idx;
        errs = err_count;
        for (int k = 0; k < 6; k++) begin
            r = lcg_rand();
            // most negative and minus one first, then random
            imm12 = (k == 0) ? 12'h800 : (k == 1) ? 12'hfff : r[31:20];
            case (k % 3)
                0: begin
                    op = ctrl_pkg::OP_IMM;
                    fu = ctrl_pkg::FU_ALU;
                end
                1: begin
                    op = ctrl_pkg::OP_LOAD;
                    fu = ctrl_pkg::FU_LSU;
                end
                default: begin
                    op = ctrl_pkg::OP_JALR;
                    fu = ctrl_pkg::FU_BRU;
                end
            endcase
            // two's complement value of imm12
            exp_imm = imm12;
            if (imm12[11]) begin
                exp_imm = exp_imm - 32'd4096;
            end
            idx     = next_idx;
            send_inst("imm_decode", make_i(op, r[4:0], r[9:5], imm12));
            @(negedge clk);
            i_inst_valid = 1'b0;
            check_disp("imm_decode", fu, r[4:0], 1'b1, r[9:5], '0, exp_imm, idx);
            retire_one("imm_decode", idx);
        end
        report_test("imm_decode", errs);
    endtask

    task automatic test_illegal();
        int                             errs;
        ctrl_pkg::inst_word_t           w;
        logic [ctrl_pkg::ROB_IDX_W-1:0] idx;
        errs = err_count;
        for (int k = 0; k < 2; k++) begin
            w = lcg_rand();
            w.r_fmt.opcode = (k == 0) ? 7'b1111111 : 7'b0110111;
            idx = next_idx;
            send_inst("illegal", w);
            @(negedge clk);
            i_inst_valid = 1'b0;
            check_disp("illegal", ctrl_pkg::FU_ILLEGAL, '0, 1'b0, '0, '0, '0, idx);
            // done at allocation, commits with no writeback
            check_commit("illegal", 1'b1, idx, 1'b1);
            @(negedge clk);
            check_commit("illegal", 1'b0, '0, 1'b0);
        end
        report_test("illegal", errs);
    endtask

    task automatic test_backpressure();
        int                             errs;
        logic [ctrl_pkg::ROB_IDX_W-1:0] idx0;
        logic [ctrl_pkg::ROB_IDX_W-1:0] idx1;
        errs = err_count;
        i_disp_ready = 1'b0;
        idx0 = next_idx;
        send_inst("backpressure", make_r(5'd1, 5'd2, 5'd3));
        @(negedge clk);
        i_inst = make_r(5'd4, 5'd5, 5'd6);
        idx1   = next_idx;
        for (int k = 0; k < 3; k++) begin
            check_disp("backpressure", ctrl_pkg::FU_ALU, 5'd1, 1'b1, 5'd2, 5'd3, '0, idx0);
            #(CLK_PERIOD/4);
            check_ready("backpressure", 1'b0);
            @(negedge clk);
        end
        check_disp("backpressure", ctrl_pkg::FU_ALU, 5'd1, 1'b1, 5'd2, 5'd3, '0, idx0);
        // release, old packet leaves as the new one loads
        i_disp_ready = 1'b1;
        send_inst("backpressure", make_r(5'd4, 5'd5, 5'd6));
        @(negedge clk);
        i_inst_valid = 1'b0;
        check_disp("backpressure", ctrl_pkg::FU_ALU, 5'd4, 1'b1, 5'd5, 5'd6, '0, idx1);
        @(negedge clk);
        if (o_disp_valid !== 1'b0) begin
            $display("backpressure: dispatch packet still valid after it was taken");
            err_count++;
        end
        retire_one("backpressure", idx0);
        retire_one("backpressure", idx1);
        report_test("backpressure", errs);
    endtask

    task automatic test_rob_full();
        int                             errs;
        int                             head;
        int                             j;
        int                             tmp;
        int                             order [8];
        logic                           done_m [8];
        logic [ctrl_pkg::ROB_IDX_W-1:0] base;
        errs = err_count;
        base = next_idx;
        for (int k = 0; k < ctrl_pkg::ROB_SIZE; k++) begin
            send_inst("rob_full", make_r(k[4:0], 5'd7, 5'd9));
            @(negedge clk);
            i_inst_valid = 1'b0;
            check_disp("rob_full", ctrl_pkg::FU_ALU, k[4:0], 1'b1, 5'd7, 5'd9, '0,
                       base + k[2:0]);
            order[k]  = k;
            done_m[k] = 1'b0;
        end
        // a ninth word must be held off
        i_inst_valid = 1'b1;
        i_inst       = make_r(5'd31, 5'd1, 5'd1);
        #(CLK_PERIOD/4);
        check_ready("rob_full", 1'b0);
        @(negedge clk);
        i_inst_valid = 1'b0;
        if (o_disp_valid !== 1'b0) begin
            $display("rob_full: an instruction was dispatched into a full rob");
            err_count++;
        end
        for (int i = ctrl_pkg::ROB_SIZE - 1; i > 0; i--) begin
            j        = lcg_rand() % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        head = 0;
        for (int i = 0; i < ctrl_pkg::ROB_SIZE; i++) begin
            i_wb_valid   = 1'b1;
            i_wb_rob_idx = base + order[i][2:0];
            @(negedge clk);
            i_wb_valid = 1'b0;
            done_m[order[i]] = 1'b1;
            // drain every head entry that is now complete
            while (head < ctrl_pkg::ROB_SIZE && done_m[head]) begin
                check_commit("rob_full", 1'b1, base + head[2:0], 1'b0);
                head++;
                @(negedge clk);
            end
            check_commit("rob_full", 1'b0, '0, 1'b0);
        end
        if (head != ctrl_pkg::ROB_SIZE) begin
            $display("rob_full: only %0d of %0d entries committed", head, ctrl_pkg::ROB_SIZE);
            err_count++;
        end
        report_test("rob_full", errs);
    endtask

    initial begin
        rng_state    = 32'h7f29;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        next_idx     = '0;
        i_rst_n      = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_disp_ready = 1'b1;
        i_wb_valid   = 1'b0;
        i_wb_rob_idx = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        @(negedge clk);
        if (o_disp_valid !== 1'b0 || o_commit_valid !== 1'b0 || o_inst_ready !== 1'b1) begin
            $display("state after reset is wrong");
            err_count++;
        end

        test_reg_decode();
        test_imm_decode();
        test_illegal();
        test_backpressure();
        test_rob_full();

        err_count += ctrl_block_inst.u_ctrl_block_chk.assert_fails;
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- flist.f
hw/ctrl_pkg.sv
hw/inst_decode.sv
hw/rob.sv
hw/dispatch_stage.sv
hw/ctrl_block.sv
tb/ctrl_block_chk.sv
tb/ctrl_block_tb.sv

//--- Bender.yml
package:
  name: ctrl_block

sources:
  - hw/ctrl_pkg.sv
  - hw/inst_decode.sv
  - hw/rob.sv
  - hw/dispatch_stage.sv
  - hw/ctrl_block.sv
  - target: test
    files:
      - tb/ctrl_block_chk.sv
      - tb/ctrl_block_tb.sv
